//--- hdl/mem_region_pkg.sv
/*
  Shared widths and sizes for the memory region.
  Both RAMs are 64 bits wide and the core side works on 32-bit words.
  Sizes must be powers of two so that the row index widths come out exact.
*/
package mem_region_pkg;

  // core side
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  // RAM rows and loader words
  typedef logic [63:0] wide_t;
  typedef logic [7:0]  wide_be_t;

  localparam int DATA_RAM_BYTES  = 4096;
  localparam int INSTR_RAM_BYTES = 4096;

  // byte address widths inside each RAM
  localparam int DADDR_W = $clog2(DATA_RAM_BYTES);
  localparam int IADDR_W = $clog2(INSTR_RAM_BYTES);

  typedef logic [DADDR_W-1:0] daddr_t;
  typedef logic [IADDR_W-1:0] iaddr_t;

  // byte offset bits inside one row, and row counts
  localparam int ROW_OFFS_W      = $clog2($bits(wide_be_t));
  localparam int DATA_RAM_ROWS   = DATA_RAM_BYTES / $bits(wide_be_t);
  localparam int INSTR_RAM_ROWS  = INSTR_RAM_BYTES / $bits(wide_be_t);

  // upper address bits that select the on-chip data RAM
  localparam int                      WIN_PREFIX_W    = 12;
  localparam logic [WIN_PREFIX_W-1:0] DATA_WIN_PREFIX = 12'h001;

  // side that owes the next load/store response
  typedef enum logic {
    RESP_RAM,
    RESP_EXT
  } resp_src_e;

endpackage

//--- hdl/sp_ram.sv
/*
  Single-port RAM of 64-bit rows with per-byte write enables.
  Read data is registered and appears one cycle after en_i.
  A write returns the old contents of the row on rdata_o.
  Contents are undefined after power-up.
*/
`timescale 1ns/1ps

module sp_ram #(
  parameter int DEPTH = 512
) (
  input  logic                         clk,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [$clog2(DEPTH)-1:0]     addr_i,
  input  mem_region_pkg::wide_t        wdata_i,
  input  mem_region_pkg::wide_be_t     be_i,
  output mem_region_pkg::wide_t        rdata_o
);

  import mem_region_pkg::*;

  wide_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // byte lanes written one by one
        for (int b = 0; b < $bits(wide_be_t); b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- hdl/ram_port_mux.sv
/*
  Shares one 64-bit single-port RAM between a wide loader port and a
  32-bit core port. The loader always wins and is never stalled; its read
  data shows up on the cycle after the request. The core waits for gnt.
  With CORE_WRITES at 0 the core port is read only.
*/
`timescale 1ns/1ps

module ram_port_mux #(
  parameter int ADDR_W      = 12,
  parameter bit CORE_WRITES = 1'b1
) (
  input  logic                                      clk,
  input  logic                                      rst_n,

  // wide loader port
  input  logic                                      wide_req_i,
  input  logic                                      wide_we_i,
  input  logic [ADDR_W-1:0]                         wide_addr_i,
  input  mem_region_pkg::wide_t                     wide_wdata_i,
  input  mem_region_pkg::wide_be_t                  wide_be_i,
  output mem_region_pkg::wide_t                     wide_rdata_o,

  // 32-bit core port
  input  logic                                      core_req_i,
  input  logic                                      core_we_i,
  input  logic [ADDR_W-1:0]                         core_addr_i,
  input  mem_region_pkg::word_t                     core_wdata_i,
  input  mem_region_pkg::be_t                       core_be_i,
  output logic                                      core_gnt_o,
  output logic                                      core_rvalid_o,
  output mem_region_pkg::word_t                     core_rdata_o,

  // RAM side
  output logic                                      ram_en_o,
  output logic                                      ram_we_o,
  output logic [ADDR_W-mem_region_pkg::ROW_OFFS_W-1:0] ram_addr_o,
  output mem_region_pkg::wide_t                     ram_wdata_o,
  output mem_region_pkg::wide_be_t                  ram_be_o,
  input  mem_region_pkg::wide_t                     ram_rdata_i
);

  import mem_region_pkg::*;

  logic     core_we;
  word_t    core_wdata;
  be_t      core_be;
  logic     core_half;
  wide_be_t core_row_be;
  logic     half_q;

  // read-only instance ignores the write inputs
  assign core_we    = CORE_WRITES ? core_we_i : 1'b0;
  assign core_wdata = CORE_WRITES ? core_wdata_i : '0;
  assign core_be    = CORE_WRITES ? core_be_i : '1;

  // address bit 2 picks the upper or lower word of the row
  assign core_half   = core_addr_i[ROW_OFFS_W-1];
  assign core_row_be = wide_be_t'(core_be) << (core_half ? $bits(be_t) : 0);

  // loader has priority
  assign core_gnt_o = core_req_i & ~wide_req_i;

  always_comb begin
    ram_en_o = wide_req_i | core_req_i;
    if (wide_req_i) begin
      ram_we_o    = wide_we_i;
      ram_addr_o  = wide_addr_i[ADDR_W-1:ROW_OFFS_W];
      ram_wdata_o = wide_wdata_i;
      ram_be_o    = wide_be_i;
    end else begin
      ram_we_o    = core_we;
      ram_addr_o  = core_addr_i[ADDR_W-1:ROW_OFFS_W];
      // same word on both halves, byte enables pick the half
      ram_wdata_o = {core_wdata, core_wdata};
      ram_be_o    = core_row_be;
    end
  end

  // response one cycle after the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_o <= 1'b0;
      half_q        <= 1'b0;
    end else begin
      core_rvalid_o <= core_gnt_o;
      if (core_gnt_o) begin
        half_q <= core_half;
      end
    end
  end

  assign core_rdata_o = half_q ? ram_rdata_i[$bits(wide_t)-1 -: $bits(word_t)]
                               : ram_rdata_i[$bits(word_t)-1:0];

  // loader read data comes straight from the RAM
  assign wide_rdata_o = ram_rdata_i;

endmodule

//--- hdl/lsu_route_ctrl.sv
/*
  Steers load/store requests to the data RAM or the external bus.
  Responses are assumed to come back in grant order; a new request to the
  other side must not be granted while a response is still owed.
*/
`timescale 1ns/1ps

module lsu_route_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,

  // load/store port of the core
  input  logic                  lsu_req_i,
  input  mem_region_pkg::word_t lsu_addr_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output mem_region_pkg::word_t lsu_rdata_o,

  // data RAM side
  output logic                  ram_req_o,
  input  logic                  ram_gnt_i,
  input  logic                  ram_rvalid_i,
  input  mem_region_pkg::word_t ram_rdata_i,

  // external bus side
  output logic                  ext_req_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  mem_region_pkg::word_t ext_rdata_i
);

  import mem_region_pkg::*;

  logic      in_window;
  resp_src_e resp_src_q;
  resp_src_e resp_src_d;

  // address decode on the upper bits
  assign in_window = (lsu_addr_i[$bits(word_t)-1 -: WIN_PREFIX_W] == DATA_WIN_PREFIX);

  assign ram_req_o = lsu_req_i & in_window;
  assign ext_req_o = lsu_req_i & ~in_window;

  // grant from whichever side the request went to
  always_comb begin
    resp_src_d = resp_src_q;
    lsu_gnt_o  = 1'b0;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      if (ext_gnt_i) begin
        resp_src_d = RESP_EXT;
      end
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      if (ram_gnt_i) begin
        resp_src_d = RESP_RAM;
      end
    end
  end

  // remembers the side of the last granted request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= RESP_RAM;
    end else begin
      resp_src_q <= resp_src_d;
    end
  end

  // only one side can answer in a given cycle
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = (resp_src_q == RESP_EXT) ? ext_rdata_i : ram_rdata_i;

endmodule

//--- hdl/mem_region_top.sv
/*
  Memory region around a core: instruction RAM, data RAM and a route to
  the external bus for every load/store outside the 0x001xxxxx window.
  Loader ports are served in the cycle they are raised and stall the core
  port of the same RAM. Fetch addresses are not range checked.
*/
`timescale 1ns/1ps

module mem_region_top (
  input  logic                     clk,
  input  logic                     rst_n,

  // instruction fetch
  input  logic                     fetch_req_i,
  input  mem_region_pkg::word_t    fetch_addr_i,
  output logic                     fetch_gnt_o,
  output logic                     fetch_rvalid_o,
  output mem_region_pkg::word_t    fetch_rdata_o,

  // load/store
  input  logic                     lsu_req_i,
  input  logic                     lsu_we_i,
  input  mem_region_pkg::word_t    lsu_addr_i,
  input  mem_region_pkg::word_t    lsu_wdata_i,
  input  mem_region_pkg::be_t      lsu_be_i,
  output logic                     lsu_gnt_o,
  output logic                     lsu_rvalid_o,
  output mem_region_pkg::word_t    lsu_rdata_o,

  // external bus
  output logic                     ext_req_o,
  output logic                     ext_we_o,
  output mem_region_pkg::word_t    ext_addr_o,
  output mem_region_pkg::word_t    ext_wdata_o,
  output mem_region_pkg::be_t      ext_be_o,
  input  logic                     ext_gnt_i,
  input  logic                     ext_rvalid_i,
  input  mem_region_pkg::word_t    ext_rdata_i,

  // data RAM loader
  input  logic                     dmem_req_i,
  input  logic                     dmem_we_i,
  input  mem_region_pkg::daddr_t   dmem_addr_i,
  input  mem_region_pkg::wide_t    dmem_wdata_i,
  input  mem_region_pkg::wide_be_t dmem_be_i,
  output mem_region_pkg::wide_t    dmem_rdata_o,

  // instruction RAM loader
  input  logic                     imem_req_i,
  input  logic                     imem_we_i,
  input  mem_region_pkg::iaddr_t   imem_addr_i,
  input  mem_region_pkg::wide_t    imem_wdata_i,
  input  mem_region_pkg::wide_be_t imem_be_i,
  output mem_region_pkg::wide_t    imem_rdata_o
);

  import mem_region_pkg::*;

  // load/store to data RAM
  logic  ram_req;
  logic  ram_gnt;
  logic  ram_rvalid;
  word_t ram_rdata;

  // instruction RAM
  logic                          iram_en;
  logic                          iram_we;
  logic [IADDR_W-ROW_OFFS_W-1:0] iram_addr;
  wide_t                         iram_wdata;
  wide_be_t                      iram_be;
  wide_t                         iram_rdata;

  // data RAM
  logic                          dram_en;
  logic                          dram_we;
  logic [DADDR_W-ROW_OFFS_W-1:0] dram_addr;
  wide_t                         dram_wdata;
  wide_be_t                      dram_be;
  wide_t                         dram_rdata;

  // external bus sees the load/store payload unchanged
  assign ext_we_o    = lsu_we_i;
  assign ext_addr_o  = lsu_addr_i;
  assign ext_wdata_o = lsu_wdata_i;
  assign ext_be_o    = lsu_be_i;

  lsu_route_ctrl lsu_route (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ram_req_o    (ram_req),
    .ram_gnt_i    (ram_gnt),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata),
    .ext_req_o    (ext_req_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i)
  );

  // fetch side, read only
  ram_port_mux #(
    .ADDR_W      (IADDR_W),
    .CORE_WRITES (1'b0)
  ) instr_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .wide_req_i    (imem_req_i),
    .wide_we_i     (imem_we_i),
    .wide_addr_i   (imem_addr_i),
    .wide_wdata_i  (imem_wdata_i),
    .wide_be_i     (imem_be_i),
    .wide_rdata_o  (imem_rdata_o),
    .core_req_i    (fetch_req_i),
    .core_we_i     (),
    .core_addr_i   (fetch_addr_i[IADDR_W-1:0]),
    .core_wdata_i  (),
    .core_be_i     (),
    .core_gnt_o    (fetch_gnt_o),
    .core_rvalid_o (fetch_rvalid_o),
    .core_rdata_o  (fetch_rdata_o),
    .ram_en_o      (iram_en),
    .ram_we_o      (iram_we),
    .ram_addr_o    (iram_addr),
    .ram_wdata_o   (iram_wdata),
    .ram_be_o      (iram_be),
    .ram_rdata_i   (iram_rdata)
  );

  sp_ram #(
    .DEPTH (INSTR_RAM_ROWS)
  ) instr_ram (
    .clk     (clk),
    .en_i    (iram_en),
    .we_i    (iram_we),
    .addr_i  (iram_addr),
    .wdata_i (iram_wdata),
    .be_i    (iram_be),
    .rdata_o (iram_rdata)
  );

  ram_port_mux #(
    .ADDR_W      (DADDR_W),
    .CORE_WRITES (1'b1)
  ) data_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .wide_req_i    (dmem_req_i),
    .wide_we_i     (dmem_we_i),
    .wide_addr_i   (dmem_addr_i),
    .wide_wdata_i  (dmem_wdata_i),
    .wide_be_i     (dmem_be_i),
    .wide_rdata_o  (dmem_rdata_o),
    .core_req_i    (ram_req),
    .core_we_i     (lsu_we_i),
    .core_addr_i   (lsu_addr_i[DADDR_W-1:0]),
    .core_wdata_i  (lsu_wdata_i),
    .core_be_i     (lsu_be_i),
    .core_gnt_o    (ram_gnt),
    .core_rvalid_o (ram_rvalid),
    .core_rdata_o  (ram_rdata),
    .ram_en_o      (dram_en),
    .ram_we_o      (dram_we),
    .ram_addr_o    (dram_addr),
    .ram_wdata_o   (dram_wdata),
    .ram_be_o      (dram_be),
    .ram_rdata_i   (dram_rdata)
  );

  sp_ram #(
    .DEPTH (DATA_RAM_ROWS)
  ) data_ram (
    .clk     (clk),
    .en_i    (dram_en),
    .we_i    (dram_we),
    .addr_i  (dram_addr),
    .wdata_i (dram_wdata),
    .be_i    (dram_be),
    .rdata_o (dram_rdata)
  );

endmodule

//--- include/mem_region_tb_table.svh
/*
  Stimulus and expected values for the memory region testbench, included
  inside the testbench module. Loader and fetch addresses use only the low
  bits inside the RAM. Rows are read only after the table has written them.
*/
`ifndef MEM_REGION_TB_TABLE_SVH
`define MEM_REGION_TB_TABLE_SVH

typedef enum logic [3:0] {
  OP_LSU_WR,
  OP_LSU_RD,
  OP_FETCH,
  OP_DMEM_WR,
  OP_DMEM_RD,
  OP_IMEM_WR,
  OP_IMEM_RD,
  OP_HOLD_WR,
  OP_HOLD_RD
} op_e;

localparam int NUM_ENTRIES = 24;

op_e         op_tab   [NUM_ENTRIES];
logic [31:0] addr_tab [NUM_ENTRIES];
logic [63:0] data_tab [NUM_ENTRIES];
logic [7:0]  be_tab   [NUM_ENTRIES];
logic [63:0] exp_tab  [NUM_ENTRIES];

task automatic set_entry(input int idx, input op_e op, input logic [31:0] addr,
                         input logic [63:0] data, input logic [7:0] be,
                         input logic [63:0] exp);
  op_tab[idx]   = op;
  addr_tab[idx] = addr;
  data_tab[idx] = data;
  be_tab[idx]   = be;
  exp_tab[idx]  = exp;
endtask

// each entry gives index, operation, address, write data, byte enables and expected read value
task automatic fill_table();
  // row later aliased by the external writes
  set_entry( 0, OP_DMEM_WR, 32'h0000_0040, 64'h1111_2222_3333_4444, 8'hff, 64'h0);
  // byte merge, then both halves of one row
  set_entry( 1, OP_LSU_WR,  32'h0010_0010, 64'hdead_beef, 8'h0f, 64'h0);
  set_entry( 2, OP_LSU_WR,  32'h0010_0010, 64'h0000_5a00, 8'h02, 64'h0);
  set_entry( 3, OP_LSU_RD,  32'h0010_0010, 64'h0, 8'h0f, 64'hdead_5aef);
  set_entry( 4, OP_LSU_WR,  32'h0010_0014, 64'hcafe_f00d, 8'h0f, 64'h0);
  set_entry( 5, OP_DMEM_RD, 32'h0000_0010, 64'h0, 8'h00, 64'hcafe_f00d_dead_5aef);
  // loader row seen by the core
  set_entry( 6, OP_DMEM_WR, 32'h0000_0100, 64'h0123_4567_89ab_cdef, 8'hff, 64'h0);
  set_entry( 7, OP_LSU_RD,  32'h0010_0100, 64'h0, 8'h0f, 64'h89ab_cdef);
  set_entry( 8, OP_LSU_RD,  32'h0010_0104, 64'h0, 8'h0f, 64'h0123_4567);
  // outside the window, low bits alias row 0x040
  set_entry( 9, OP_LSU_WR,  32'h2000_0040, 64'h0bad_f00d, 8'h0f, 64'h0);
  set_entry(10, OP_LSU_WR,  32'h2000_0044, 64'h7777_8888, 8'h03, 64'h0);
  set_entry(11, OP_DMEM_RD, 32'h0000_0040, 64'h0, 8'h00, 64'h1111_2222_3333_4444);
  set_entry(12, OP_LSU_RD,  32'h2000_0040, 64'h0, 8'h0f, 64'h85a5_a5e5);
  set_entry(13, OP_LSU_RD,  32'h0010_0100, 64'h0, 8'h0f, 64'h89ab_cdef);
  set_entry(14, OP_LSU_RD,  32'h8000_1234, 64'h0, 8'h0f, 64'h25a5_b791);
  set_entry(15, OP_LSU_RD,  32'h0010_0014, 64'h0, 8'h0f, 64'hcafe_f00d);
  // loader request held over a core request
  set_entry(16, OP_HOLD_WR, 32'h0010_0104, 64'h4444_5555, 8'h0f, 64'h0);
  set_entry(17, OP_LSU_RD,  32'h0010_0104, 64'h0, 8'h0f, 64'h4444_5555);
  set_entry(18, OP_HOLD_RD, 32'h0010_0100, 64'h0, 8'h0f, 64'h89ab_cdef);
  // instruction side
  set_entry(19, OP_IMEM_WR, 32'h0000_0080, 64'hfeed_face_0bad_c0de, 8'hff, 64'h0);
  set_entry(20, OP_FETCH,   32'h0000_0080, 64'h0, 8'h00, 64'h0bad_c0de);
  set_entry(21, OP_FETCH,   32'h0000_0084, 64'h0, 8'h00, 64'hfeed_face);
  set_entry(22, OP_DMEM_RD, 32'h0000_0100, 64'h0, 8'h00, 64'h4444_5555_89ab_cdef);
  // instruction row read back through the loader
  set_entry(23, OP_IMEM_RD, 32'h0000_0080, 64'h0, 8'h00, 64'hfeed_face_0bad_c0de);
endtask

`endif

//--- dv/mem_region_tb.sv
/*
  Testbench for mem_region_top. Runs the entries of the table in order,
  one at a time. The external bus slave answers with random latency and
  returns the address XOR a5a5a5a5 as read data.
*/
`timescale 1ns/1ps

module mem_region_tb;

  import mem_region_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int HOLD_CYCLES  = 3;

  logic     clk;
  logic     rst_n;
  logic     fetch_req_i, fetch_gnt_o, fetch_rvalid_o;
  word_t    fetch_addr_i, fetch_rdata_o;
  logic     lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  word_t    lsu_addr_i, lsu_wdata_i, lsu_rdata_o;
  be_t      lsu_be_i, ext_be_o;
  logic     ext_req_o, ext_we_o, ext_gnt_i, ext_rvalid_i;
  word_t    ext_addr_o, ext_wdata_o, ext_rdata_i;
  logic     dmem_req_i, dmem_we_i, imem_req_i, imem_we_i;
  daddr_t   dmem_addr_i;
  iaddr_t   imem_addr_i;
  wide_t    dmem_wdata_i, dmem_rdata_o, imem_wdata_i, imem_rdata_o;
  wide_be_t dmem_be_i, imem_be_i;

  int          error_count = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state;

  `include "mem_region_tb_table.svh"

  // each entry needs at most about ten cycles
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 12 * NUM_ENTRIES + 50;

  mem_region_top mem_region_top_inst (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles with the table unfinished", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic value_error(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    $display("Error: %s is %0h, expected %0h", name, got, exp);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    error_count++;
  endtask

  task automatic record_result(input string label, input int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("%s: pass", label);
    end else begin
      fail_count++;
      $display("%s: fail", label);
    end
  endtask

  // load/store access with the dmem loader optionally held over it
  task automatic lsu_access(input int idx, input logic we, input logic hold);
    word_t addr;
    logic  in_window;
    addr      = addr_tab[idx];
    // on-chip data window is 0x001xxxxx
    in_window = (addr[31:20] == 12'h001);
    @(posedge clk);
    #1;
    lsu_req_i   = 1'b1;
    lsu_we_i    = we;
    lsu_addr_i  = addr;
    lsu_wdata_i = data_tab[idx][31:0];
    lsu_be_i    = be_tab[idx][3:0];
    if (hold) begin
      dmem_req_i  = 1'b1;
      dmem_we_i   = 1'b0;
      dmem_addr_i = addr[DADDR_W-1:0];
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        if (lsu_gnt_o) begin
          report_failure("lsu_gnt_o went high while the dmem loader request was active");
        end
      end
      @(posedge clk);
      #1;
      dmem_req_i = 1'b0;
    end
    @(negedge clk);
    while (!lsu_gnt_o) begin
      @(negedge clk);
    end
    if (ext_req_o !== !in_window) begin
      value_error("ext_req_o", ext_req_o, !in_window);
    end
    if (!in_window) begin
      if (ext_addr_o !== addr) begin
        value_error("ext_addr_o", ext_addr_o, addr);
      end
      if (ext_we_o !== we) begin
        value_error("ext_we_o", ext_we_o, we);
      end
      if (ext_wdata_o !== data_tab[idx][31:0]) begin
        value_error("ext_wdata_o", ext_wdata_o, data_tab[idx][31:0]);
      end
      if (ext_be_o !== be_tab[idx][3:0]) begin
        value_error("ext_be_o", ext_be_o, be_tab[idx][3:0]);
      end
    end
    @(posedge clk);
    #1;
    lsu_req_i = 1'b0;
    @(negedge clk);
    if (in_window && !lsu_rvalid_o) begin
      report_failure("lsu_rvalid_o did not come one cycle after lsu_gnt_o");
    end
    while (!lsu_rvalid_o) begin
      @(negedge clk);
    end
    if (!we && lsu_rdata_o !== exp_tab[idx][31:0]) begin
      value_error("lsu_rdata_o", lsu_rdata_o, exp_tab[idx][31:0]);
    end
  endtask

  task automatic fetch_access(input int idx);
    @(posedge clk);
    #1;
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr_tab[idx];
    @(negedge clk);
    while (!fetch_gnt_o) begin
      @(negedge clk);
    end
    if (fetch_rvalid_o) begin
      report_failure("fetch_rvalid_o was already high in the grant cycle");
    end
    @(posedge clk);
    #1;
    fetch_req_i = 1'b0;
    @(negedge clk);
    if (!fetch_rvalid_o) begin
      report_failure("fetch_rvalid_o did not come one cycle after fetch_gnt_o");
    end else if (fetch_rdata_o !== exp_tab[idx][31:0]) begin
      value_error("fetch_rdata_o", fetch_rdata_o, exp_tab[idx][31:0]);
    end
  endtask

  // loader ports serve the request in the cycle it is raised
  task automatic loader_access(input int idx, input logic imem, input logic we);
    @(posedge clk);
    #1;
    if (imem) begin
      imem_req_i   = 1'b1;
      imem_we_i    = we;
      imem_addr_i  = addr_tab[idx][IADDR_W-1:0];
      imem_wdata_i = data_tab[idx];
      imem_be_i    = be_tab[idx];
    end else begin
      dmem_req_i   = 1'b1;
      dmem_we_i    = we;
      dmem_addr_i  = addr_tab[idx][DADDR_W-1:0];
      dmem_wdata_i = data_tab[idx];
      dmem_be_i    = be_tab[idx];
    end
    @(posedge clk);
    #1;
    imem_req_i = 1'b0;
    dmem_req_i = 1'b0;
    @(negedge clk);
    if (!imem && !we && dmem_rdata_o !== exp_tab[idx]) begin
      value_error("dmem_rdata_o", dmem_rdata_o, exp_tab[idx]);
    end
    if (imem && !we && imem_rdata_o !== exp_tab[idx]) begin
      value_error("imem_rdata_o", imem_rdata_o, exp_tab[idx]);
    end
  endtask

  // external bus slave that grants after 0..3 cycles and answers 1..4 cycles later
  initial begin : ext_responder
    int    gnt_wait;
    int    resp_wait;
    word_t addr;
    word_t wdata;
    be_t   be;
    logic  we;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    rng_state    = 32'h7084;
    forever begin
      @(posedge clk);
      #2;
      if (ext_req_o) begin
        addr      = ext_addr_o;
        wdata     = ext_wdata_o;
        be        = ext_be_o;
        we        = ext_we_o;
        rng_state = xorshift32(rng_state);
        gnt_wait  = rng_state % 4;
        rng_state = xorshift32(rng_state);
        resp_wait = 1 + rng_state % 4;
        repeat (gnt_wait) begin
          @(posedge clk);
          #2;
        end
        ext_gnt_i = 1'b1;
        @(posedge clk);
        #2;
        ext_gnt_i = 1'b0;
        if (we) begin
          $display("ext bus write addr %h data %h be %h", addr, wdata, be);
        end
        repeat (resp_wait - 1) begin
          @(posedge clk);
          #2;
        end
        ext_rdata_i  = we ? '0 : (addr ^ 32'ha5a5_a5a5);
        ext_rvalid_i = 1'b1;
        @(posedge clk);
        #2;
        ext_rvalid_i = 1'b0;
      end
    end
  end

  initial begin
    int errors_before;
    rst_n        = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    lsu_req_i    = 1'b0;
    lsu_we_i     = 1'b0;
    lsu_addr_i   = '0;
    lsu_wdata_i  = '0;
    lsu_be_i     = '0;
    dmem_req_i   = 1'b0;
    dmem_we_i    = 1'b0;
    dmem_addr_i  = '0;
    dmem_wdata_i = '0;
    dmem_be_i    = '0;
    imem_req_i   = 1'b0;
    imem_we_i    = 1'b0;
    imem_addr_i  = '0;
    imem_wdata_i = '0;
    imem_be_i    = '0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle outputs right after reset
    @(negedge clk);
    errors_before = error_count;
    if (lsu_gnt_o !== 1'b0) begin
      value_error("lsu_gnt_o", lsu_gnt_o, 0);
    end
    if (lsu_rvalid_o !== 1'b0) begin
      value_error("lsu_rvalid_o", lsu_rvalid_o, 0);
    end
    if (fetch_gnt_o !== 1'b0) begin
      value_error("fetch_gnt_o", fetch_gnt_o, 0);
    end
    if (fetch_rvalid_o !== 1'b0) begin
      value_error("fetch_rvalid_o", fetch_rvalid_o, 0);
    end
    if (ext_req_o !== 1'b0) begin
      value_error("ext_req_o", ext_req_o, 0);
    end
    record_result("reset state", errors_before);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      errors_before = error_count;
      case (op_tab[i])
        OP_LSU_WR:  lsu_access(i, 1'b1, 1'b0);
        OP_LSU_RD:  lsu_access(i, 1'b0, 1'b0);
        OP_HOLD_WR: lsu_access(i, 1'b1, 1'b1);
        OP_HOLD_RD: lsu_access(i, 1'b0, 1'b1);
        OP_FETCH:   fetch_access(i);
        OP_DMEM_WR: loader_access(i, 1'b0, 1'b1);
        OP_DMEM_RD: loader_access(i, 1'b0, 1'b0);
        OP_IMEM_WR: loader_access(i, 1'b1, 1'b1);
        OP_IMEM_RD: loader_access(i, 1'b1, 1'b0);
        default:    report_failure("table entry has an unknown operation");
      endcase
      record_result($sformatf("entry %0d %s addr %h", i, op_tab[i].name(), addr_tab[i]),
                    errors_before);
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
hdl/mem_region_pkg.sv
hdl/sp_ram.sv
hdl/ram_port_mux.sv
hdl/lsu_route_ctrl.sv
hdl/mem_region_top.sv
dv/mem_region_tb.sv
